// File: source/imuldiv_pkg.sv
// ----------------------------------------------------------
// shared constants and types for the iterative mul/div unit
// the datapaths are written for XLEN = 32 only
// ----------------------------------------------------------

package imuldiv_pkg;

  // ----------------------------------------------------------
  // widths and iteration count
  // ----------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int RLEN       = 64;
  // one datapath step per operand bit
  localparam int ITERATIONS = 32;
  // counter runs ITERATIONS-1 down to 0
  localparam int CNT_W      = 5;

  // control FSM state codes
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CALC = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  // ----------------------------------------------------------
  // function codes
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    // signed multiply, full 64-bit product
    FN_MUL  = 2'd0,
    // signed divide
    FN_DIV  = 2'd1,
    // unsigned divide
    FN_DIVU = 2'd2
  } imuldiv_fn_t;

  // ----------------------------------------------------------
  // response word
  // ----------------------------------------------------------
  // divide view, remainder in the upper half
  typedef struct packed {
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quot;
  } imuldiv_qr_t;

  // one 64-bit word, read as product or as quotient/remainder
  typedef union packed {
    logic [RLEN-1:0] product;
    imuldiv_qr_t     qr;
  } imuldiv_result_t;

endpackage

// File: source/imuldiv_ctrl.sv
// ----------------------------------------------------------
// control FSM, one operation in flight
// first CALC cycle is a setup cycle, then 32 step cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_ctrl import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  imuldiv_fn_t req_fn,
  input  logic        req_val,
  input  logic        resp_rdy,
  output logic        req_rdy,
  output logic        resp_val,
  output logic        load,
  output logic        mul_step,
  output logic        div_step,
  output imuldiv_fn_t fn
);

  logic [1:0]       state_q;
  logic [CNT_W-1:0] cnt_q;
  // high during the cycle after accept, datapaths load from the
  // freshly registered magnitudes then
  logic             setup_q;
  imuldiv_fn_t      fn_q;

  logic accept;
  logic respond;
  logic calc_active;

  // ----------------------------------------------------------
  // handshake and step decode
  // ----------------------------------------------------------
  assign req_rdy  = (state_q == ST_IDLE);
  assign resp_val = (state_q == ST_DONE);
  assign accept   = req_val && req_rdy;
  assign respond  = resp_val && resp_rdy;

  // operand_prep captures on the accept edge
  assign load = accept;

  assign calc_active = (state_q == ST_CALC) && !setup_q;
  // exactly one datapath advances, chosen by the registered fn
  assign mul_step = calc_active && (fn_q == FN_MUL);
  assign div_step = calc_active && (fn_q != FN_MUL);
  assign fn       = fn_q;

  // ----------------------------------------------------------
  // state, counter and function register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      setup_q <= 1'b0;
      fn_q    <= FN_MUL;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_CALC;
            cnt_q   <= CNT_W'(ITERATIONS - 1);
            setup_q <= 1'b1;
            fn_q    <= req_fn;
          end
        end
        ST_CALC: begin
          setup_q <= 1'b0;
          // last step happens with the counter at zero
          if (calc_active) begin
            if (cnt_q == '0) begin
              state_q <= ST_DONE;
            end else begin
              cnt_q <= cnt_q - 1'b1;
            end
          end
        end
        ST_DONE: begin
          // hold the response under back-pressure
          if (respond) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  // only one datapath may consume a step
  a_one_step: assert property (@(posedge clk) disable iff (reset)
    !(mul_step && div_step));

  // no new request while a response is pending
  a_busy_while_resp: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy);

endmodule

// File: source/imuldiv_operand_prep.sv
// ----------------------------------------------------------
// captures operand magnitudes and flags on the accept edge
// req_a/req_b only need to be valid in the load cycle
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_operand_prep import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  logic [XLEN-1:0] req_a,
  input  logic [XLEN-1:0] req_b,
  input  imuldiv_fn_t     req_fn,
  output logic [XLEN-1:0] mag_a,
  output logic [XLEN-1:0] mag_b,
  output logic            neg_a,
  output logic            neg_b,
  output logic            b_zero,
  output logic            a_min,
  output logic            b_minus_one
);

  logic is_signed;
  logic sign_a;
  logic sign_b;

  // unsigned divide keeps raw operands
  assign is_signed = (req_fn != FN_DIVU);
  assign sign_a    = is_signed && req_a[XLEN-1];
  assign sign_b    = is_signed && req_b[XLEN-1];

  // magnitudes, payload only
  always_ff @(posedge clk) begin
    if (load) begin
      mag_a <= sign_a ? (~req_a + 1'b1) : req_a;
      mag_b <= sign_b ? (~req_b + 1'b1) : req_b;
    end
  end

  // sign and special-case flags from the raw operands
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_a       <= 1'b0;
      neg_b       <= 1'b0;
      b_zero      <= 1'b0;
      a_min       <= 1'b0;
      b_minus_one <= 1'b0;
    end else if (load) begin
      neg_a       <= sign_a;
      neg_b       <= sign_b;
      b_zero      <= (req_b == '0);
      // overflow pair, meaningful for signed codes only
      a_min       <= is_signed && (req_a == {1'b1, {(XLEN-1){1'b0}}});
      b_minus_one <= is_signed && (&req_b);
    end
  end

endmodule

// File: source/imuldiv_mul_dpath.sv
// ----------------------------------------------------------
// shift-and-add multiplier on unsigned magnitudes
// multiplicand and multiplier load one cycle after load
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_mul_dpath import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  logic            mul_step,
  input  logic [XLEN-1:0] mag_a,
  input  logic [XLEN-1:0] mag_b,
  output logic [RLEN-1:0] product_mag
);

  // mag_a/mag_b become valid the cycle after load
  logic            load_q;
  logic [RLEN-1:0] mcand_q;
  logic [XLEN-1:0] mplier_q;
  logic [RLEN-1:0] acc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      load_q <= 1'b0;
    end else begin
      load_q <= load;
    end
  end

  // ----------------------------------------------------------
  // operand shift registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_q) begin
      mcand_q  <= {{(RLEN-XLEN){1'b0}}, mag_a};
      mplier_q <= mag_b;
    end else if (mul_step) begin
      // multiplicand moves up one weight per step
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // ----------------------------------------------------------
  // accumulator
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      acc_q <= '0;
    end else if (mul_step && mplier_q[0]) begin
      // partial product only when the current multiplier bit is set
      acc_q <= acc_q + mcand_q;
    end
  end

  assign product_mag = acc_q;

  // result must hold through DONE while the consumer stalls
  a_acc_hold: assert property (@(posedge clk) disable iff (reset)
    (!load && !mul_step) |=> $stable(acc_q));

endmodule

// File: source/imuldiv_div_dpath.sv
// ----------------------------------------------------------
// restoring divider on unsigned magnitudes
// zero divisor yields all-ones quotient, dividend as remainder
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            load,
  input  logic            div_step,
  input  logic [XLEN-1:0] mag_a,
  input  logic [XLEN-1:0] mag_b,
  output logic [XLEN-1:0] quot_mag,
  output logic [XLEN-1:0] rem_mag
);

  logic            load_q;
  // remainder, upper half of the shifting pair
  logic [XLEN-1:0] rem_q;
  // dividend bits shift out the top, quotient bits enter below
  logic [XLEN-1:0] quot_q;
  logic [XLEN-1:0] divisor_q;

  // one extra bit for the shifted remainder, one more for the borrow
  logic [XLEN:0]   shifted;
  logic [XLEN+1:0] diff;
  logic            fits;

  always_ff @(posedge clk) begin
    if (reset) begin
      load_q <= 1'b0;
    end else begin
      load_q <= load;
    end
  end

  // ----------------------------------------------------------
  // trial subtract
  // ----------------------------------------------------------
  assign shifted = {rem_q, quot_q[XLEN-1]};
  assign diff    = {1'b0, shifted} - {2'b00, divisor_q};
  // no borrow means the divisor fits
  assign fits    = !diff[XLEN+1];

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      rem_q <= '0;
    end else if (div_step) begin
      // a kept remainder is always below the divisor, so 32 bits hold it
      rem_q <= fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (load_q) begin
      quot_q    <= mag_a;
      divisor_q <= mag_b;
    end else if (div_step) begin
      quot_q <= {quot_q[XLEN-2:0], fits};
    end
  end

  assign quot_mag = quot_q;
  assign rem_mag  = rem_q;

endmodule

// File: source/imuldiv_result_fixup.sv
// ----------------------------------------------------------
// sign correction and special cases, purely combinational
// inputs are held stable through DONE by the datapaths
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_result_fixup import imuldiv_pkg::*; (
  input  imuldiv_fn_t     fn,
  input  logic [RLEN-1:0] product_mag,
  input  logic [XLEN-1:0] quot_mag,
  input  logic [XLEN-1:0] rem_mag,
  input  logic            neg_a,
  input  logic            neg_b,
  input  logic            b_zero,
  input  logic            a_min,
  input  logic            b_minus_one,
  output imuldiv_result_t resp_result
);

  logic            neg_res;
  logic            overflow;
  logic [RLEN-1:0] prod_fix;
  logic [XLEN-1:0] quot_fix;
  logic [XLEN-1:0] rem_fix;

  // result sign for product and quotient
  assign neg_res  = neg_a ^ neg_b;
  // most negative / -1, signed divide only
  assign overflow = (fn == FN_DIV) && a_min && b_minus_one;

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------
  assign prod_fix = neg_res ? (~product_mag + 1'b1) : product_mag;

  always_comb begin
    // zero divisor: all ones, never negated
    if (b_zero) begin
      quot_fix = '1;
    end else if (overflow) begin
      quot_fix = {1'b1, {(XLEN-1){1'b0}}};
    end else if (neg_res) begin
      quot_fix = ~quot_mag + 1'b1;
    end else begin
      quot_fix = quot_mag;
    end

    // remainder follows the dividend sign
    // with a zero divisor rem_mag is the dividend magnitude,
    // so this also rebuilds the raw dividend
    if (overflow) begin
      rem_fix = '0;
    end else if (neg_a) begin
      rem_fix = ~rem_mag + 1'b1;
    end else begin
      rem_fix = rem_mag;
    end
  end

  // ----------------------------------------------------------
  // response word
  // ----------------------------------------------------------
  always_comb begin
    if (fn == FN_MUL) begin
      resp_result.product = prod_fix;
    end else begin
      resp_result.qr.quot = quot_fix;
      resp_result.qr.rem  = rem_fix;
    end
  end

endmodule

// File: source/imuldiv_iterative.sv
// ----------------------------------------------------------
// iterative signed mul / signed and unsigned div, 32-bit
// fixed 33-cycle latency from accept to resp_val
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_iterative import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [XLEN-1:0] req_a,
  input  logic [XLEN-1:0] req_b,
  input  imuldiv_fn_t     req_fn,
  input  logic            req_val,
  output logic            req_rdy,
  output imuldiv_result_t resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  // control to datapath
  logic        load;
  logic        mul_step;
  logic        div_step;
  imuldiv_fn_t fn;

  // operand_prep outputs
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;
  logic            neg_a;
  logic            neg_b;
  logic            b_zero;
  logic            a_min;
  logic            b_minus_one;

  // raw datapath results
  logic [RLEN-1:0] product_mag;
  logic [XLEN-1:0] quot_mag;
  logic [XLEN-1:0] rem_mag;

  imuldiv_ctrl imuldiv_ctrl_inst (
    .clk      (clk),
    .reset    (reset),
    .req_fn   (req_fn),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .load     (load),
    .mul_step (mul_step),
    .div_step (div_step),
    .fn       (fn)
  );

  imuldiv_operand_prep imuldiv_operand_prep_inst (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .mag_a       (mag_a),
    .mag_b       (mag_b),
    .neg_a       (neg_a),
    .neg_b       (neg_b),
    .b_zero      (b_zero),
    .a_min       (a_min),
    .b_minus_one (b_minus_one)
  );

  imuldiv_mul_dpath imuldiv_mul_dpath_inst (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .mul_step    (mul_step),
    .mag_a       (mag_a),
    .mag_b       (mag_b),
    .product_mag (product_mag)
  );

  imuldiv_div_dpath imuldiv_div_dpath_inst (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .div_step (div_step),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

  imuldiv_result_fixup imuldiv_result_fixup_inst (
    .fn          (fn),
    .product_mag (product_mag),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .neg_a       (neg_a),
    .neg_b       (neg_b),
    .b_zero      (b_zero),
    .a_min       (a_min),
    .b_minus_one (b_minus_one),
    .resp_result (resp_result)
  );

endmodule

// File: verif/imuldiv_tb.sv
// ----------------------------------------------------------
// random testbench for the iterative mul/div unit, seed 81412
// inputs change on the falling edge, outputs sampled there too
// ----------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_tb import imuldiv_pkg::*; ();

  // accept to resp_val, one setup cycle plus one per step
  localparam int LATENCY   = ITERATIONS + 1;
  localparam int NUM_MUL   = 300;
  localparam int NUM_DIV   = 300;
  localparam int NUM_ZERO  = 16;
  localparam int NUM_BUSY  = 2;
  localparam int NUM_STALL = 30;
  localparam int NUM_OPS   = NUM_MUL + 2 * NUM_DIV + NUM_ZERO + NUM_BUSY + NUM_STALL;
  localparam logic [XLEN-1:0] MIN_VAL = 32'h8000_0000;

  logic            clk;
  logic            reset;
  logic [XLEN-1:0] req_a;
  logic [XLEN-1:0] req_b;
  imuldiv_fn_t     req_fn;
  logic            req_val;
  logic            req_rdy;
  imuldiv_result_t resp_result;
  logic            resp_val;
  logic            resp_rdy;

  int seed = 81412;
  int checks;
  int errors;
  int checks_start;
  int errors_start;
  int tests;

  imuldiv_iterative imuldiv_iterative_inst (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_fn      (req_fn),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // budget of 40 cycles per operation plus slack for reset
  initial begin
    repeat (NUM_OPS * 40 + 200) @(posedge clk);
    $display("watchdog: run timed out before all tests completed");
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic imuldiv_result_t model(input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b,
                                            input imuldiv_fn_t f);
    logic signed [RLEN-1:0] sa;
    logic signed [RLEN-1:0] sb;
    logic signed [RLEN-1:0] q;
    logic signed [RLEN-1:0] r;
    imuldiv_result_t res;
    sa = {{XLEN{a[XLEN-1]}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    res.product = '0;
    if (f == FN_MUL) begin
      res.product = sa * sb;
    end else if (b == '0) begin
      // zero divisor, all ones and the raw dividend
      res.qr.quot = '1;
      res.qr.rem  = a;
    end else if (f == FN_DIV && a == MIN_VAL && b == '1) begin
      res.qr.quot = MIN_VAL;
      res.qr.rem  = '0;
    end else if (f == FN_DIV) begin
      // truncating divide, remainder keeps the dividend sign
      q = sa / sb;
      r = sa % sb;
      res.qr.quot = q[XLEN-1:0];
      res.qr.rem  = r[XLEN-1:0];
    end else begin
      res.qr.quot = a / b;
      res.qr.rem  = a % b;
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic check_product(input imuldiv_result_t got, input imuldiv_result_t exp,
                               input string what);
    checks++;
    if (got.product !== exp.product) begin
      errors++;
      $display("CHECK FAILED at %0t: %s product got %h exp %h",
               $time, what, got.product, exp.product);
    end
  endtask

  task automatic check_divide(input imuldiv_result_t got, input imuldiv_result_t exp,
                              input string what);
    checks++;
    if (got.qr.quot !== exp.qr.quot || got.qr.rem !== exp.qr.rem) begin
      errors++;
      $display("CHECK FAILED at %0t: %s quot %h rem %h exp quot %h rem %h",
               $time, what, got.qr.quot, got.qr.rem, exp.qr.quot, exp.qr.rem);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b exp %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s latency %0d exp %0d", $time, what, got, exp);
    end
  endtask

  // picks the view that matches the function code
  task automatic compare_response(input imuldiv_result_t got, input imuldiv_result_t exp,
                                  input imuldiv_fn_t f, input string what);
    if (f == FN_MUL) begin
      check_product(got, exp, what);
    end else begin
      check_divide(got, exp, what);
    end
  endtask

  // ----------------------------------------------------------
  // stimulus helpers, all entered right after a falling edge
  // ----------------------------------------------------------
  function automatic logic [XLEN-1:0] pick_operand();
    logic [XLEN-1:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    return '0;
      3'd1:    return 32'd1;
      3'd2:    return '1;
      3'd3:    return MIN_VAL;
      default: return $random(seed);
    endcase
  endfunction

  function automatic imuldiv_fn_t pick_fn();
    logic [XLEN-1:0] r;
    r = $random(seed);
    case (r % 3)
      0:       return FN_MUL;
      1:       return FN_DIV;
      default: return FN_DIVU;
    endcase
  endfunction

  // returns at the falling edge after the accept edge
  task automatic issue(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                       input imuldiv_fn_t f);
    req_a   = a;
    req_b   = b;
    req_fn  = f;
    req_val = 1'b1;
    while (!req_rdy) @(negedge clk);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // counts cycles to resp_val, holds off the response, then takes it
  task automatic collect(input imuldiv_fn_t f, input int stall,
                         output imuldiv_result_t res, output int lat);
    lat = 0;
    while (!resp_val) begin
      check_flag(req_rdy, 1'b0, "req_rdy while busy");
      @(negedge clk);
      lat++;
    end
    res = resp_result;
    repeat (stall) begin
      @(negedge clk);
      check_flag(resp_val, 1'b1, "resp_val under back-pressure");
      check_flag(req_rdy, 1'b0, "req_rdy under back-pressure");
      compare_response(resp_result, res, f, "held result");
    end
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
    check_flag(resp_val, 1'b0, "resp_val after transfer");
    check_flag(req_rdy, 1'b1, "req_rdy after transfer");
  endtask

  task automatic run_op(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                        input imuldiv_fn_t f, input int stall);
    imuldiv_result_t got;
    imuldiv_result_t exp;
    int lat;
    exp = model(a, b, f);
    issue(a, b, f);
    collect(f, stall, got, lat);
    check_latency(lat, LATENCY, "accept to resp_val");
    compare_response(got, exp, f, $sformatf("%s a %h b %h", f.name(), a, b));
  endtask

  task automatic start_test();
    checks_start = checks;
    errors_start = errors;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %-14s %0d checks, %0d errors", name,
             checks - checks_start, errors - errors_start);
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    imuldiv_result_t got;
    imuldiv_result_t exp1;
    imuldiv_result_t exp2;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    int lat;
    int stall;
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_fn   = FN_MUL;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    checks   = 0;
    errors   = 0;
    tests    = 0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    start_test();
    check_flag(req_rdy, 1'b1, "req_rdy after reset");
    check_flag(resp_val, 1'b0, "resp_val after reset");
    report_test("reset");

    start_test();
    for (int i = 0; i < NUM_MUL; i++) begin
      run_op(pick_operand(), pick_operand(), FN_MUL, 0);
    end
    report_test("mul_random");

    // signed and unsigned divide, overflow pair forced now and then
    start_test();
    for (int i = 0; i < NUM_DIV; i++) begin
      a = pick_operand();
      b = pick_operand();
      if (i % 50 == 7) begin
        a = MIN_VAL;
        b = '1;
      end
      run_op(a, b, FN_DIV, 0);
    end
    report_test("div_random");

    start_test();
    for (int i = 0; i < NUM_DIV; i++) begin
      run_op(pick_operand(), pick_operand(), FN_DIVU, 0);
    end
    report_test("divu_random");

    start_test();
    for (int i = 0; i < NUM_ZERO / 2; i++) begin
      case (i)
        0:       a = '0;
        1:       a = 32'd1;
        2:       a = '1;
        3:       a = MIN_VAL;
        4:       a = 32'h7fff_ffff;
        default: a = $random(seed);
      endcase
      run_op(a, '0, FN_DIV, 0);
      run_op(a, '0, FN_DIVU, 0);
    end
    report_test("div_by_zero");

    // second request waits on the port during the whole first operation
    start_test();
    exp1 = model(32'h1234_5678, 32'hfedc_ba98, FN_MUL);
    exp2 = model(32'h8765_4321, 32'd7, FN_DIV);
    issue(32'h1234_5678, 32'hfedc_ba98, FN_MUL);
    req_a   = 32'h8765_4321;
    req_b   = 32'd7;
    req_fn  = FN_DIV;
    req_val = 1'b1;
    collect(FN_MUL, 0, got, lat);
    check_latency(lat, LATENCY, "first request");
    check_product(got, exp1, "first request");
    issue(32'h8765_4321, 32'd7, FN_DIV);
    collect(FN_DIV, 0, got, lat);
    check_latency(lat, LATENCY, "held request");
    check_divide(got, exp2, "held request");
    report_test("latency_busy");

    start_test();
    for (int i = 0; i < NUM_STALL; i++) begin
      stall = 1 + ($unsigned($random(seed)) % 15);
      run_op(pick_operand(), pick_operand(), pick_fn(), stall);
    end
    report_test("back_pressure");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
source/imuldiv_pkg.sv
source/imuldiv_ctrl.sv
source/imuldiv_operand_prep.sv
source/imuldiv_mul_dpath.sv
source/imuldiv_div_dpath.sv
source/imuldiv_result_fixup.sv
source/imuldiv_iterative.sv
verif/imuldiv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mul/div testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module imuldiv_tb \
  -f list.f -o imuldiv_sim > sim.log 2>&1 \
  && ./obj_dir/imuldiv_sim >> sim.log 2>&1 \
  || echo "build or run returned an error" >> sim.log

cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
